// File: include/gru_consts.svh
`ifndef GRU_CONSTS_SVH
`define GRU_CONSTS_SVH

// word widths
`define GRU_DATA_W      16
`define GRU_WEIGHT_W    8
`define GRU_ACC_W       24

// Q8.8 fixed point
`define GRU_FRAC_W      8
`define GRU_ONE         256
`define GRU_HALF        128

// tanh table, covers |x| < 4.0
`define GRU_TANH_DEPTH  1024
`define GRU_TANH_ADDR_W 10

// neuron index wraps at 256
`define GRU_NEURON_W    8

`endif

// File: design/gru_pkg.sv
`include "gru_consts.svh"

package gru_pkg;

	// Q8.8 data word
	typedef logic signed [`GRU_DATA_W-1:0] q88_t;

	// weight or bias, sign-extended into Q8.8 before use
	typedef logic signed [`GRU_WEIGHT_W-1:0] weight_t;

	// lane accumulator, wide enough for a full neuron without wrap
	typedef logic signed [`GRU_ACC_W-1:0] acc_t;

	// running neuron number
	typedef logic [`GRU_NEURON_W-1:0] neuron_t;

endpackage

// File: design/gate_sum_if.sv
`timescale 1ns/10ps

interface gate_sum_if
	import gru_pkg::*;
();

	// one strobe per finished neuron
	logic    valid;
	q88_t    sum;
	logic    sat;
	neuron_t neuron;

	modport producer (
		output valid,
		output sum,
		output sat,
		output neuron
	);

	modport consumer (
		input valid,
		input sum,
		input sat,
		input neuron
	);

endinterface

// File: design/gate_mac.sv
`timescale 1ns/10ps
`include "gru_consts.svh"

module gate_mac
	import gru_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         valid_i,
	input  logic         last_i,
	input  q88_t         x_i,
	input  weight_t      w_i,
	input  weight_t      bias_i,
	gate_sum_if.producer sum_o
);

	// high while the next element opens a new neuron
	logic first_q;

	acc_t acc_q;
	acc_t acc_base;
	acc_t acc_next;
	acc_t prod_sh;

	q88_t w_ext;
	logic signed [2*`GRU_DATA_W-1:0] prod;

	// bits above the 16-bit sign position
	logic [`GRU_ACC_W-`GRU_DATA_W:0] acc_hi;
	logic fits;
	q88_t sum_clamped;

	neuron_t neuron_q;
	neuron_t neuron_out_q;
	logic    valid_q;
	logic    sat_q;
	q88_t    sum_q;

	always_comb begin
		w_ext = {{(`GRU_DATA_W-`GRU_WEIGHT_W){w_i[`GRU_WEIGHT_W-1]}}, w_i};
		prod = w_ext * x_i;
		// Q8.8 x Q8.8, drop the extra fraction bits
		prod_sh = acc_t'(prod >>> `GRU_FRAC_W);

		if (first_q) begin
			acc_base = {{(`GRU_ACC_W-`GRU_WEIGHT_W){bias_i[`GRU_WEIGHT_W-1]}}, bias_i};
		end else begin
			acc_base = acc_q;
		end
		acc_next = acc_base + prod_sh;

		acc_hi = acc_next[`GRU_ACC_W-1:`GRU_DATA_W-1];
		fits = (&acc_hi) | ~(|acc_hi);
		if (fits) begin
			sum_clamped = acc_next[`GRU_DATA_W-1:0];
		end else if (acc_next[`GRU_ACC_W-1]) begin
			sum_clamped = {1'b1, {(`GRU_DATA_W-1){1'b0}}};
		end else begin
			sum_clamped = {1'b0, {(`GRU_DATA_W-1){1'b1}}};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			first_q  <= 1'b1;
			valid_q  <= 1'b0;
			sat_q    <= 1'b0;
			neuron_q <= '0;
		end else begin
			valid_q <= valid_i & last_i;
			if (valid_i) begin
				first_q <= last_i;
				if (last_i) begin
					sat_q    <= ~fits;
					neuron_q <= neuron_q + neuron_t'(1);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (valid_i) begin
			acc_q <= acc_next;
		end
		if (valid_i & last_i) begin
			sum_q        <= sum_clamped;
			neuron_out_q <= neuron_q;
		end
	end

	assign sum_o.valid  = valid_q;
	assign sum_o.sum    = sum_q;
	assign sum_o.sat    = sat_q;
	assign sum_o.neuron = neuron_out_q;

	// the source must never close a neuron on an idle cycle
	last_needs_valid: assert property (
		@(posedge clk) disable iff (rst)
		last_i |-> valid_i
	) else $error("gate_mac: last_i without valid_i");

endmodule

// File: design/gate_activation.sv
`timescale 1ns/10ps
`include "gru_consts.svh"

module gate_activation
	import gru_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	gate_sum_if.consumer z_sum_i,
	gate_sum_if.consumer r_sum_i,
	output logic         out_valid_o,
	output q88_t         z_o,
	output q88_t         r_o,
	output neuron_t      neuron_o,
	output logic         sat_o
);

	// 256*tanh(k/256), k = 0 .. 1023
	q88_t tanh_rom [`GRU_TANH_DEPTH];

	q88_t z_half;
	q88_t r_half;
	logic [`GRU_TANH_ADDR_W-1:0] z_addr;
	logic [`GRU_TANH_ADDR_W-1:0] r_addr;
	q88_t z_gate;
	q88_t r_gate;

	logic    valid_q;
	logic    sat_q;
	q88_t    z_q;
	q88_t    r_q;
	neuron_t neuron_q;

	function automatic q88_t tanh_entry(input int k);
		real v;
		v = real'(`GRU_ONE) * $tanh(real'(k) / real'(`GRU_ONE));
		// rounded to nearest, entries are never negative
		return q88_t'($rtoi(v + 0.5));
	endfunction

	initial begin
		for (int k = 0; k < `GRU_TANH_DEPTH; k++) begin
			tanh_rom[k] = tanh_entry(k);
		end
	end

	// table index from |s|, low bits only
	function automatic logic [`GRU_TANH_ADDR_W-1:0] mag_addr(input q88_t s);
		q88_t mag;
		mag = s[`GRU_DATA_W-1] ? -s : s;
		return mag[`GRU_TANH_ADDR_W-1:0];
	endfunction

	// tanh with saturation outside +-4.0, then 0.5*tanh + 0.5
	function automatic q88_t sigmoid_out(input q88_t s, input q88_t tab);
		q88_t t;
		if (s[`GRU_DATA_W-1:`GRU_TANH_ADDR_W] !=
		    {(`GRU_DATA_W-`GRU_TANH_ADDR_W){s[`GRU_DATA_W-1]}}) begin
			t = s[`GRU_DATA_W-1] ? q88_t'(-`GRU_ONE) : q88_t'(`GRU_ONE);
		end else begin
			t = s[`GRU_DATA_W-1] ? -tab : tab;
		end
		return (t >>> 1) + q88_t'(`GRU_HALF);
	endfunction

	always_comb begin
		// sigmoid(x) = 0.5 + 0.5*tanh(x/2)
		z_half = z_sum_i.sum >>> 1;
		r_half = r_sum_i.sum >>> 1;
		z_addr = mag_addr(z_half);
		r_addr = mag_addr(r_half);
		z_gate = sigmoid_out(z_half, tanh_rom[z_addr]);
		r_gate = sigmoid_out(r_half, tanh_rom[r_addr]);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
			sat_q   <= 1'b0;
		end else begin
			valid_q <= z_sum_i.valid;
			if (z_sum_i.valid) begin
				sat_q <= z_sum_i.sat | r_sum_i.sat;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (z_sum_i.valid) begin
			z_q      <= z_gate;
			r_q      <= r_gate;
			neuron_q <= z_sum_i.neuron;
		end
	end

	assign out_valid_o = valid_q;
	assign z_o         = z_q;
	assign r_o         = r_q;
	assign neuron_o    = neuron_q;
	assign sat_o       = sat_q;

	// both lanes see the same strobes, so they finish together
	lanes_in_step: assert property (
		@(posedge clk) disable iff (rst)
		z_sum_i.valid == r_sum_i.valid
	) else $error("gate_activation: z and r lanes strobe apart");

	lanes_same_neuron: assert property (
		@(posedge clk) disable iff (rst)
		z_sum_i.valid |-> (z_sum_i.neuron == r_sum_i.neuron)
	) else $error("gate_activation: z and r lanes disagree on neuron");

endmodule

// File: design/gru_gate_top.sv
`timescale 1ns/10ps

module gru_gate_top
	import gru_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    in_valid_i,
	input  logic    in_last_i,
	input  q88_t    x_i,
	input  weight_t wz_i,
	input  weight_t wr_i,
	input  weight_t bz_i,
	input  weight_t br_i,
	output logic    out_valid_o,
	output q88_t    z_o,
	output q88_t    r_o,
	output neuron_t neuron_o,
	output logic    sat_o
);

	gate_sum_if z_sum ();
	gate_sum_if r_sum ();

	// update gate lane
	gate_mac u_mac_z (
		.clk     (clk),
		.rst     (rst),
		.valid_i (in_valid_i),
		.last_i  (in_last_i),
		.x_i     (x_i),
		.w_i     (wz_i),
		.bias_i  (bz_i),
		.sum_o   (z_sum)
	);

	// reset gate lane
	gate_mac u_mac_r (
		.clk     (clk),
		.rst     (rst),
		.valid_i (in_valid_i),
		.last_i  (in_last_i),
		.x_i     (x_i),
		.w_i     (wr_i),
		.bias_i  (br_i),
		.sum_o   (r_sum)
	);

	gate_activation u_act (
		.clk         (clk),
		.rst         (rst),
		.z_sum_i     (z_sum),
		.r_sum_i     (r_sum),
		.out_valid_o (out_valid_o),
		.z_o         (z_o),
		.r_o         (r_o),
		.neuron_o    (neuron_o),
		.sat_o       (sat_o)
	);

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
	end

endmodule

// File: include/gru_gate_cases.svh
`ifndef GRU_GATE_CASES_SVH
`define GRU_GATE_CASES_SVH

// columns: len, bz, br, x[0:3], wz[0:3], wr[0:3], expected z, r, sat
localparam int NUM_CASES = 12;

localparam gate_case_t CASE_TABLE [NUM_CASES] = '{
	// zero sum
	'{1, 8'sd0, 8'sd0, '{16'sd0, 16'sd0, 16'sd0, 16'sd0},
	  '{8'sd0, 8'sd0, 8'sd0, 8'sd0}, '{8'sd0, 8'sd0, 8'sd0, 8'sd0},
	  16'sd128, 16'sd128, 1'b0},
	// bias only, +-0.25
	'{1, 8'sd64, -8'sd64, '{16'sd0, 16'sd0, 16'sd0, 16'sd0},
	  '{8'sd0, 8'sd0, 8'sd0, 8'sd0}, '{8'sd0, 8'sd0, 8'sd0, 8'sd0},
	  16'sd144, 16'sd112, 1'b0},
	'{1, 8'sd127, 8'sh80, '{16'sd0, 16'sd0, 16'sd0, 16'sd0},
	  '{8'sd0, 8'sd0, 8'sd0, 8'sd0}, '{8'sd0, 8'sd0, 8'sd0, 8'sd0},
	  16'sd159, 16'sd96, 1'b0},
	// -127 halves to -64 like -128
	'{1, 8'sd100, -8'sd127, '{16'sd0, 16'sd0, 16'sd0, 16'sd0},
	  '{8'sd0, 8'sd0, 8'sd0, 8'sd0}, '{8'sd0, 8'sd0, 8'sd0, 8'sd0},
	  16'sd152, 16'sd96, 1'b0},
	// single element, sums of +-1.0
	'{1, 8'sd64, -8'sd64, '{16'sd768, 16'sd0, 16'sd0, 16'sd0},
	  '{8'sd64, 8'sd0, 8'sd0, 8'sd0}, '{-8'sd64, 8'sd0, 8'sd0, 8'sd0},
	  16'sd187, 16'sd69, 1'b0},
	// sums of +-4.0
	'{1, 8'sd0, 8'sd0, '{16'sd4096, 16'sd0, 16'sd0, 16'sd0},
	  '{8'sd64, 8'sd0, 8'sd0, 8'sd0}, '{-8'sd64, 8'sd0, 8'sd0, 8'sd0},
	  16'sd251, 16'sd4, 1'b0},
	// three elements, mixed signs
	'{3, 8'sd0, 8'sd0, '{16'sd256, 16'sd512, -16'sd256, 16'sd0},
	  '{8'sd32, 8'sd32, 8'sd32, 8'sd0}, '{-8'sd16, 8'sd16, 8'sd64, 8'sd0},
	  16'sd144, 16'sd116, 1'b0},
	// truncation of small negative products
	'{4, 8'sd0, 8'sd0, '{-16'sd1, -16'sd1, -16'sd1, -16'sd1},
	  '{8'sd1, 8'sd1, 8'sd1, 8'sd1}, '{-8'sd1, -8'sd1, -8'sd1, -8'sd1},
	  16'sd127, 16'sd128, 1'b0},
	// beyond the table range, no clamp
	'{1, 8'sd0, 8'sd0, '{16'sh7FFF, 16'sd0, 16'sd0, 16'sd0},
	  '{8'sd127, 8'sd0, 8'sd0, 8'sd0}, '{8'sh80, 8'sd0, 8'sd0, 8'sd0},
	  16'sd256, 16'sd0, 1'b0},
	// both lanes clamp
	'{4, 8'sd0, 8'sd0, '{16'sh7FFF, 16'sh7FFF, 16'sh7FFF, 16'sh7FFF},
	  '{8'sd127, 8'sd127, 8'sd127, 8'sd127}, '{8'sh80, 8'sh80, 8'sh80, 8'sh80},
	  16'sd256, 16'sd0, 1'b1},
	// only z clamps
	'{4, 8'sd0, 8'sd0, '{16'sh7FFF, 16'sh7FFF, 16'sh7FFF, 16'sh7FFF},
	  '{8'sd127, 8'sd127, 8'sd127, 8'sd127}, '{8'sd0, 8'sd0, 8'sd0, 8'sd0},
	  16'sd256, 16'sd128, 1'b1},
	// negative clamp with bias, r at -2.0
	'{3, 8'sh80, 8'sh80, '{16'sh8000, 16'sh8000, 16'sh8000, 16'sd0},
	  '{8'sd127, 8'sd127, 8'sd127, 8'sd0}, '{8'sd1, 8'sd1, 8'sd1, 8'sd0},
	  16'sd0, 16'sd30, 1'b1}
};

`endif

// File: bench/gru_gate_tb.sv
`timescale 1ns/10ps
`include "gru_consts.svh"

module gru_gate_tb
	import gru_pkg::*;
();

	localparam int MAX_LEN     = 42;
	localparam int NUM_RAND    = 300;
	localparam int MAX_ELEMS   = NUM_RAND * MAX_LEN;
	localparam int LATENCY     = 2;
	localparam int DRAIN_LIMIT = 200;
	localparam int Q_MAX       = (1 << (`GRU_DATA_W - 1)) - 1;
	localparam int Q_MIN       = -(1 << (`GRU_DATA_W - 1));

	typedef struct packed {
		int            len;
		weight_t       bz;
		weight_t       br;
		q88_t    [0:3] x;
		weight_t [0:3] wz;
		weight_t [0:3] wr;
		q88_t          exp_z;
		q88_t          exp_r;
		logic          exp_sat;
	} gate_case_t;

	typedef struct packed {
		q88_t    z;
		q88_t    r;
		logic    sat;
		neuron_t neuron;
		int      cyc;
	} expect_t;

	`include "gru_gate_cases.svh"

	logic    clk;
	logic    rst;
	logic    in_valid;
	logic    in_last;
	q88_t    x_in;
	weight_t wz_in;
	weight_t wr_in;
	weight_t bz_in;
	weight_t br_in;
	logic    out_valid;
	q88_t    z_gate;
	q88_t    r_gate;
	neuron_t neuron_idx;
	logic    sat_flag;

	int          tanh_ref [`GRU_TANH_DEPTH];
	logic [31:0] lcg_state = 32'd52;
	int          cyc = 0;
	int          err_cnt = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	neuron_t     exp_neuron = '0;
	expect_t     exp_q [$];

	// neuron being sent
	int      cur_len;
	weight_t cur_bz;
	weight_t cur_br;
	q88_t    cur_x [MAX_LEN];
	weight_t cur_wz [MAX_LEN];
	weight_t cur_wr [MAX_LEN];

	// random neurons kept for the second pass
	int      rnd_len [NUM_RAND];
	int      rnd_start [NUM_RAND];
	weight_t rnd_bz [NUM_RAND];
	weight_t rnd_br [NUM_RAND];
	q88_t    rnd_x [MAX_ELEMS];
	weight_t rnd_wz [MAX_ELEMS];
	weight_t rnd_wr [MAX_ELEMS];

	tb_clock u_clock (
		.clk_o (clk)
	);

	gru_gate_top u_gru_gate_top (
		.clk         (clk),
		.rst         (rst),
		.in_valid_i  (in_valid),
		.in_last_i   (in_last),
		.x_i         (x_in),
		.wz_i        (wz_in),
		.wr_i        (wr_in),
		.bz_i        (bz_in),
		.br_i        (br_in),
		.out_valid_o (out_valid),
		.z_o         (z_gate),
		.r_o         (r_gate),
		.neuron_o    (neuron_idx),
		.sat_o       (sat_flag)
	);

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		// low LCG bits repeat quickly so fold the high bits down
		return lcg_state ^ (lcg_state >> 15);
	endfunction

	function automatic bit out_of_range(input int v);
		return (v > Q_MAX) || (v < Q_MIN);
	endfunction

	function automatic int clamp16(input int v);
		if (v > Q_MAX) begin
			return Q_MAX;
		end else if (v < Q_MIN) begin
			return Q_MIN;
		end
		return v;
	endfunction

	// 0.5 * tanh(S/2) + 0.5 with the table limited to |s| < 4.0
	function automatic int sigmoid_ref(input int sum);
		int s;
		int t;
		int mag;
		s = sum >>> 1;
		if (s > `GRU_TANH_DEPTH - 1) begin
			t = `GRU_ONE;
		end else if (s < -`GRU_TANH_DEPTH) begin
			t = -`GRU_ONE;
		end else begin
			mag = (s < 0) ? -s : s;
			t = tanh_ref[mag % `GRU_TANH_DEPTH];
			if (s < 0) begin
				t = -t;
			end
		end
		return (t >>> 1) + `GRU_HALF;
	endfunction

	function automatic expect_t model_neuron();
		acc_t    acc_z;
		acc_t    acc_r;
		expect_t e;
		e = '0;
		acc_z = acc_t'(cur_bz);
		acc_r = acc_t'(cur_br);
		for (int i = 0; i < cur_len; i++) begin
			acc_z = acc_z + acc_t'((int'(cur_wz[i]) * int'(cur_x[i])) >>> `GRU_FRAC_W);
			acc_r = acc_r + acc_t'((int'(cur_wr[i]) * int'(cur_x[i])) >>> `GRU_FRAC_W);
		end
		e.z = q88_t'(sigmoid_ref(clamp16(int'(acc_z))));
		e.r = q88_t'(sigmoid_ref(clamp16(int'(acc_r))));
		e.sat = out_of_range(int'(acc_z)) || out_of_range(int'(acc_r));
		return e;
	endfunction

	task automatic check_equal(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic drive_idle();
		@(negedge clk);
		in_valid = 1'b0;
		in_last = 1'b0;
		// garbage on the data lines must be ignored
		x_in = q88_t'(next_rand());
	endtask

	task automatic send_current(input expect_t e, input bit with_gaps);
		int gap;
		for (int i = 0; i < cur_len; i++) begin
			if (with_gaps) begin
				gap = int'(next_rand() % 4);
				repeat (gap) drive_idle();
			end
			@(negedge clk);
			in_valid = 1'b1;
			in_last = (i == cur_len - 1);
			x_in = cur_x[i];
			wz_in = cur_wz[i];
			wr_in = cur_wr[i];
			bz_in = cur_bz;
			br_in = cur_br;
		end
		e.neuron = exp_neuron;
		e.cyc = cyc;
		exp_q.push_back(e);
		exp_neuron++;
	endtask

	task automatic wait_results(input string test_name);
		int waited;
		waited = 0;
		drive_idle();
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout in %s: result for neuron %0d never arrived",
				test_name, exp_q[0].neuron);
			err_cnt++;
			exp_q.delete();
		end
	endtask

	task automatic finish_test(input string test_name, input int errs_before);
		if (err_cnt == errs_before) begin
			$display("%s: ok", test_name);
			tests_passed++;
		end else begin
			$display("%s: %0d errors", test_name, err_cnt - errs_before);
			tests_failed++;
		end
	endtask

	task automatic load_case(input int c);
		cur_len = CASE_TABLE[c].len;
		cur_bz = CASE_TABLE[c].bz;
		cur_br = CASE_TABLE[c].br;
		for (int i = 0; i < 4; i++) begin
			cur_x[i] = CASE_TABLE[c].x[i];
			cur_wz[i] = CASE_TABLE[c].wz[i];
			cur_wr[i] = CASE_TABLE[c].wr[i];
		end
	endtask

	task automatic make_random();
		logic [31:0] r;
		q88_t        xv;
		int          pos;
		pos = 0;
		for (int n = 0; n < NUM_RAND; n++) begin
			r = next_rand();
			rnd_len[n] = 1 + int'(r % MAX_LEN);
			rnd_bz[n] = weight_t'(r[15:8]);
			rnd_br[n] = weight_t'(r[23:16]);
			rnd_start[n] = pos;
			for (int i = 0; i < rnd_len[n]; i++) begin
				r = next_rand();
				xv = q88_t'(r[15:0]);
				// vary magnitude so sums land inside and outside the table
				rnd_x[pos] = xv >>> {r[17:16], 1'b0};
				rnd_wz[pos] = weight_t'(r[25:18]);
				r = next_rand();
				rnd_wr[pos] = weight_t'(r[7:0]);
				pos++;
			end
		end
	endtask

	task automatic load_random(input int n);
		cur_len = rnd_len[n];
		cur_bz = rnd_bz[n];
		cur_br = rnd_br[n];
		for (int i = 0; i < cur_len; i++) begin
			cur_x[i] = rnd_x[rnd_start[n] + i];
			cur_wz[i] = rnd_wz[rnd_start[n] + i];
			cur_wr[i] = rnd_wr[rnd_start[n] + i];
		end
	endtask

	// results are sampled away from the rising edge
	always @(negedge clk) begin : monitor
		expect_t e;
		if (!rst && out_valid) begin
			if (exp_q.size() == 0) begin
				$display("Error at %0t: result for neuron %0d arrived with none pending",
					$time, neuron_idx);
				err_cnt++;
			end else begin
				e = exp_q.pop_front();
				check_equal("z_o", int'(z_gate), int'(e.z));
				check_equal("r_o", int'(r_gate), int'(e.r));
				check_equal("sat_o", int'(sat_flag), int'(e.sat));
				check_equal("neuron_o", int'(neuron_idx), int'(e.neuron));
				check_equal("latency", cyc - e.cyc, LATENCY);
			end
		end
	end

	initial begin
		int      errs;
		string   name;
		expect_t e;
		for (int k = 0; k < `GRU_TANH_DEPTH; k++) begin
			tanh_ref[k] = $rtoi(real'(`GRU_ONE) * $tanh(real'(k) / real'(`GRU_ONE)) + 0.5);
		end
		rst = 1'b1;
		in_valid = 1'b0;
		in_last = 1'b0;
		x_in = '0;
		wz_in = '0;
		wr_in = '0;
		bz_in = '0;
		br_in = '0;

		errs = err_cnt;
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			check_equal("out_valid_o in reset", int'(out_valid), 0);
			check_equal("sat_o in reset", int'(sat_flag), 0);
		end
		rst = 1'b0;
		repeat (3) begin
			@(negedge clk);
			check_equal("out_valid_o after reset", int'(out_valid), 0);
			check_equal("sat_o after reset", int'(sat_flag), 0);
		end
		finish_test("reset", errs);

		for (int c = 0; c < NUM_CASES; c++) begin
			errs = err_cnt;
			name = $sformatf("directed case %0d", c);
			load_case(c);
			e = model_neuron();
			check_equal({name, " model z"}, int'(e.z), int'(CASE_TABLE[c].exp_z));
			check_equal({name, " model r"}, int'(e.r), int'(CASE_TABLE[c].exp_r));
			check_equal({name, " model sat"}, int'(e.sat), int'(CASE_TABLE[c].exp_sat));
			e.z = CASE_TABLE[c].exp_z;
			e.r = CASE_TABLE[c].exp_r;
			e.sat = CASE_TABLE[c].exp_sat;
			send_current(e, 1'b0);
			wait_results(name);
			finish_test(name, errs);
		end

		make_random();
		errs = err_cnt;
		for (int n = 0; n < NUM_RAND; n++) begin
			load_random(n);
			send_current(model_neuron(), 1'b0);
		end
		wait_results("random back to back");
		finish_test("random back to back", errs);

		errs = err_cnt;
		for (int n = 0; n < NUM_RAND; n++) begin
			load_random(n);
			send_current(model_neuron(), 1'b1);
		end
		wait_results("random with gaps");
		finish_test("random with gaps", errs);

		$display("tests passed: %0d, tests failed: %0d, check errors: %0d",
			tests_passed, tests_failed, err_cnt);
		if (tests_failed == 0 && err_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+include
design/gru_pkg.sv
design/gate_sum_if.sv
design/gate_mac.sv
design/gate_activation.sv
design/gru_gate_top.sv
bench/tb_clock.sv
bench/gru_gate_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the GRU gate testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module gru_gate_tb -f flist.f -o gru_gate_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/gru_gate_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TB PASSED"; then
	exit 0
fi

echo "pass message not found in simulation output"
exit 1
